// ==== common/cart_pkg.sv ====
/*
 Cartridge loader package
 Widths, header offsets, chip codes and the structs shared by the
 download, header, chip detect and memory request blocks
*/
package cart_pkg;

	// ============================================================
	// Vector types
	// ============================================================
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_word_t;
	typedef logic [22:0] rom_word_addr_t;
	typedef logic [23:0] mask_t;
	// Map type in [1:0], chip code in [7:4]
	typedef logic [7:0] rom_type_t;
	typedef logic [15:0] aram_addr_t;
	typedef logic [7:0] hdr_byte_t;

	// ============================================================
	// Constants
	// ============================================================
	localparam logic [5:0] IDX_SPC = 6'd2;
	localparam dl_addr_t ARAM_LIMIT = 25'h0010100;
	localparam dl_addr_t ARAM_OFFSET = 25'd256;

	// Internal header word offsets within the bank
	localparam logic [14:0] HDR_MAPPER = 15'h7FD4;
	localparam logic [14:0] HDR_TYPE = 15'h7FD6;
	localparam logic [14:0] HDR_RAMSIZE = 15'h7FD8;
	localparam logic [14:0] HDR_COMPANY = 15'h7FDA;

	// Where the header bank sits for each map type
	localparam dl_addr_t PREFIX_LOROM = 25'h0000000;
	localparam dl_addr_t PREFIX_HIROM = 25'h0008000;
	localparam dl_addr_t PREFIX_EXHIROM = 25'h0408000;

	localparam logic [3:0] MIN_ROM_SHIFT = 4'd12;
	localparam logic [3:0] GSU_RAM_SHIFT = 4'd6;

	// Coprocessor codes, upper nibble of rom_type
	localparam logic [3:0] CHIP_DSP2 = 4'h9;
	localparam logic [3:0] CHIP_DSP3 = 4'hA;
	localparam logic [3:0] CHIP_DSP4 = 4'hB;
	localparam logic [3:0] CHIP_OBC1 = 4'hC;
	localparam logic [3:0] CHIP_SDD1 = 4'h5;
	localparam logic [3:0] CHIP_GSU = 4'h7;
	localparam logic [3:0] CHIP_SA1 = 4'h6;
	localparam logic [3:0] CHIP_ST0XX = 4'h8;

	// ============================================================
	// Structs
	// ============================================================
	typedef struct packed {
		dl_addr_t addr;
		dl_addr_t addr_adj;
		dl_word_t data;
		logic cart;
		logic spc;
	} dl_write_t;

	typedef struct packed {
		hdr_byte_t mapper;
		hdr_byte_t cart_type;
		hdr_byte_t company;
		logic [3:0] rom_size;
		logic [3:0] ram_size;
	} cart_hdr_t;

	typedef struct packed {
		rom_type_t rom_type;
		mask_t rom_mask;
		mask_t ram_mask;
	} cart_info_t;

	typedef struct packed {
		logic req;
		rom_word_addr_t addr;
	} rom_req_t;

	typedef struct packed {
		logic req;
		aram_addr_t addr;
		dl_word_t data;
	} aram_req_t;

endpackage

// ==== source/download_decode.sv ====
/*
 Download decoder
 Sorts the download stream into cartridge and sound-program files,
 strips the copier header from cartridge addresses and registers each write
*/
`timescale 1ns/10ps

module download_decode (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_wr,
	input logic ioctl_download,
	input cart_pkg::dl_addr_t ioctl_addr,
	input cart_pkg::dl_word_t ioctl_dout,
	input logic [7:0] ioctl_index,
	input logic [23:0] ioctl_filesize,
	output logic wr_strobe,
	output cart_pkg::dl_write_t wr,
	output logic cart_active,
	output logic spc_mode
);

	logic cart_dl;
	logic spc_dl;
	cart_pkg::dl_addr_t addr_adj;

	// ============================================================
	// File classification
	// ============================================================
	// Index 0 and 1 are cartridge images
	assign cart_dl = ioctl_download && (ioctl_index[5:1] == 5'd0);
	assign spc_dl = ioctl_download && (ioctl_index[5:0] == cart_pkg::IDX_SPC);

	// A copier header makes the size 512 over a multiple of 1024
	assign addr_adj = ioctl_addr - cart_pkg::dl_addr_t'(ioctl_filesize[9:0]);

	// ============================================================
	// Registered write
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_strobe <= 1'b0;
			cart_active <= 1'b0;
		end else begin
			wr_strobe <= ioctl_wr;
			cart_active <= cart_dl;
		end
	end

	// Payload only, qualified by wr_strobe downstream
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			wr.addr <= ioctl_addr;
			wr.addr_adj <= addr_adj;
			wr.data <= ioctl_dout;
			wr.cart <= cart_dl;
			wr.spc <= spc_dl;
		end
	end

	// Sound mode follows the file type of the last write
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			spc_mode <= 1'b0;
		end else if (wr_strobe) begin
			spc_mode <= wr.spc;
		end
	end

endmodule

// ==== header/header_capture.sv ====
/*
 Internal header capture
 Picks the mapper, type, size and company words out of a cartridge download
 and turns the size fields into ROM and RAM address masks
*/
`timescale 1ns/10ps

module header_capture (
	input logic clk_sys,
	input logic reset,
	input logic wr_strobe,
	input cart_pkg::dl_write_t wr,
	input logic [1:0] map_sel,
	output cart_pkg::cart_hdr_t hdr,
	output cart_pkg::mask_t rom_mask,
	output cart_pkg::mask_t ram_mask
);

	cart_pkg::dl_addr_t prefix;
	logic cart_wr;
	logic at_mapper;
	logic at_type;
	logic at_ramsize;
	logic at_company;
	logic [3:0] rom_shift;
	logic hdr_loaded;

	// Header bank base for the selected map type
	always_comb begin
		case (map_sel)
			2'd1: prefix = cart_pkg::PREFIX_HIROM;
			2'd2: prefix = cart_pkg::PREFIX_EXHIROM;
			default: prefix = cart_pkg::PREFIX_LOROM;
		endcase
	end

	assign cart_wr = wr_strobe && wr.cart;
	assign at_mapper = wr.addr_adj == (prefix | cart_pkg::dl_addr_t'(cart_pkg::HDR_MAPPER));
	assign at_type = wr.addr_adj == (prefix | cart_pkg::dl_addr_t'(cart_pkg::HDR_TYPE));
	assign at_ramsize = wr.addr_adj == (prefix | cart_pkg::dl_addr_t'(cart_pkg::HDR_RAMSIZE));
	assign at_company = wr.addr_adj == (prefix | cart_pkg::dl_addr_t'(cart_pkg::HDR_COMPANY));

	// ============================================================
	// Field capture
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr <= '0;
			hdr_loaded <= 1'b0;
		end else if (cart_wr) begin
			hdr_loaded <= 1'b1;
			// New image, forget the old RAM size
			if (wr.addr == '0)
				hdr.ram_size <= 4'd0;
			if (at_mapper)
				hdr.mapper <= wr.data[15:8];
			if (at_type)
				{hdr.rom_size, hdr.cart_type} <= wr.data[11:0];
			if (at_ramsize)
				hdr.ram_size <= wr.data[3:0];
			if (at_company)
				hdr.company <= wr.data[7:0];
		end
	end

	// ============================================================
	// Address masks
	// ============================================================
	// Small images still get a 4 MB mirror window
	assign rom_shift = (hdr.rom_size > cart_pkg::MIN_ROM_SHIFT) ? hdr.rom_size :
		cart_pkg::MIN_ROM_SHIFT;

	always_ff @(posedge clk_sys) begin
		if (reset || !hdr_loaded) begin
			rom_mask <= '0;
			ram_mask <= '0;
		end else begin
			rom_mask <= (24'd1024 << rom_shift) - 24'd1;
			if (hdr.ram_size == 4'd0)
				ram_mask <= '0;
			else
				ram_mask <= (24'd1024 << hdr.ram_size) - 24'd1;
		end
	end

endmodule

// ==== header/chip_detect.sv ====
/*
 Coprocessor detect
 Derives the chip code in rom_type from the captured header once the
 cartridge download has finished, with the GSU RAM mask override
*/
`timescale 1ns/10ps

module chip_detect (
	input logic clk_sys,
	input logic reset,
	input cart_pkg::cart_hdr_t hdr,
	input cart_pkg::mask_t rom_mask,
	input cart_pkg::mask_t ram_mask,
	input logic cart_active,
	input logic [1:0] map_sel,
	output cart_pkg::cart_info_t info
);

	cart_pkg::rom_type_t rom_type;
	logic gsu;
	cart_pkg::hdr_byte_t mapper;
	cart_pkg::hdr_byte_t ctype;

	assign mapper = hdr.mapper;
	assign ctype = hdr.cart_type;

	// ============================================================
	// Chip rules, first match wins
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_type <= '0;
			gsu <= 1'b0;
		end else if (cart_active) begin
			rom_type <= {6'd0, map_sel};
			gsu <= 1'b0;
		end else begin
			// DSP3
			if (mapper == 8'h30 && ctype == 8'h05 && hdr.company == 8'hB2) begin
				rom_type[7:4] <= cart_pkg::CHIP_DSP3;
			// DSP1 only marks bit 7
			end else if (((mapper == 8'h20 || mapper == 8'h21) && ctype == 8'h03) ||
				(mapper == 8'h30 && ctype == 8'h05) ||
				(mapper == 8'h31 && (ctype == 8'h03 || ctype == 8'h05))) begin
				rom_type[7] <= 1'b1;
			end else if (mapper == 8'h20 && ctype == 8'h05) begin
				rom_type[7:4] <= cart_pkg::CHIP_DSP2;
			end else if (mapper == 8'h30 && ctype == 8'h03) begin
				rom_type[7:4] <= cart_pkg::CHIP_DSP4;
			end else if (mapper == 8'h30 && ctype == 8'h25) begin
				rom_type[7:4] <= cart_pkg::CHIP_OBC1;
			end else if (mapper == 8'h32 && (ctype == 8'h43 || ctype == 8'h45)) begin
				rom_type[7:4] <= cart_pkg::CHIP_SDD1;
			end else if (mapper == 8'h30 && ctype == 8'hF6) begin
				rom_type[7:3] <= {cart_pkg::CHIP_ST0XX, 1'b1};
				// Smaller ST0xx boards use the other variant
				if (hdr.rom_size < 4'd10)
					rom_type[5] <= 1'b1;
			end else if (mapper == 8'h20 && (ctype == 8'h13 || ctype == 8'h14 ||
				ctype == 8'h15 || ctype == 8'h1A)) begin
				rom_type[7:4] <= cart_pkg::CHIP_GSU;
				gsu <= 1'b1;
			end else if (mapper == 8'h23 && (ctype == 8'h32 || ctype == 8'h34 ||
				ctype == 8'h35)) begin
				rom_type[7:4] <= cart_pkg::CHIP_SA1;
			end
		end
	end

	// ============================================================
	// Output
	// ============================================================
	// GSU boards get fixed work RAM regardless of the header
	always_comb begin
		info.rom_type = rom_type;
		info.rom_mask = rom_mask;
		info.ram_mask = gsu ? ((24'd1024 << cart_pkg::GSU_RAM_SHIFT) - 24'd1) : ram_mask;
	end

endmodule

// ==== source/mem_request.sv ====
/*
 Memory write requests
 Turns registered download writes into toggle requests for the
 ROM port and the audio RAM port
*/
`timescale 1ns/10ps

module mem_request (
	input logic clk_sys,
	input logic reset,
	input logic wr_strobe,
	input cart_pkg::dl_write_t wr,
	output cart_pkg::rom_req_t rom,
	output cart_pkg::dl_word_t rom_din,
	output logic rom_we,
	output cart_pkg::aram_req_t aram,
	output logic aram_we
);

	logic rom_hit;
	logic aram_hit;
	cart_pkg::dl_addr_t aram_addr_full;

	assign rom_hit = wr_strobe && wr.cart;
	// The tail of a sound file holds DSP registers, not audio RAM
	assign aram_hit = wr_strobe && wr.spc && (wr.addr < cart_pkg::ARAM_LIMIT);
	assign aram_addr_full = wr.addr - cart_pkg::ARAM_OFFSET;

	// ============================================================
	// ROM port
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom.req <= 1'b0;
			rom_we <= 1'b0;
		end else if (rom_hit) begin
			rom.req <= ~rom.req;
			rom_we <= 1'b1;
		end
	end

	// Word address from the header-stripped byte address
	always_ff @(posedge clk_sys) begin
		if (rom_hit) begin
			rom.addr <= wr.addr_adj[23:1];
			rom_din <= wr.data;
		end
	end

	// ============================================================
	// Audio RAM port
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			aram.req <= 1'b0;
		end else if (aram_hit) begin
			aram.req <= ~aram.req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (aram_hit) begin
			aram.addr <= aram_addr_full[15:0];
			aram.data <= wr.data;
		end
	end

	// Loading only ever writes
	assign aram_we = 1'b1;

endmodule

// ==== source/cart_loader_top.sv ====
/*
 Cartridge loader top level
 Connects the download decoder, header capture, chip detect and
 memory request blocks
*/
`timescale 1ns/10ps

module cart_loader_top (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_wr,
	input logic ioctl_download,
	input cart_pkg::dl_addr_t ioctl_addr,
	input cart_pkg::dl_word_t ioctl_dout,
	input logic [7:0] ioctl_index,
	input logic [23:0] ioctl_filesize,
	input logic [1:0] map_sel,
	output logic spc_mode,
	output cart_pkg::cart_info_t info,
	output cart_pkg::rom_req_t rom,
	output cart_pkg::dl_word_t rom_din,
	output logic rom_we,
	output cart_pkg::aram_req_t aram,
	output logic aram_we
);

	logic wr_strobe;
	cart_pkg::dl_write_t wr;
	logic cart_active;
	cart_pkg::cart_hdr_t hdr;
	cart_pkg::mask_t rom_mask;
	cart_pkg::mask_t ram_mask;

	download_decode u_download_decode (
		.clk_sys(clk_sys),
		.reset(reset),
		.ioctl_wr(ioctl_wr),
		.ioctl_download(ioctl_download),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.ioctl_index(ioctl_index),
		.ioctl_filesize(ioctl_filesize),
		.wr_strobe(wr_strobe),
		.wr(wr),
		.cart_active(cart_active),
		.spc_mode(spc_mode)
	);

	header_capture u_header_capture (
		.clk_sys(clk_sys),
		.reset(reset),
		.wr_strobe(wr_strobe),
		.wr(wr),
		.map_sel(map_sel),
		.hdr(hdr),
		.rom_mask(rom_mask),
		.ram_mask(ram_mask)
	);

	chip_detect u_chip_detect (
		.clk_sys(clk_sys),
		.reset(reset),
		.hdr(hdr),
		.rom_mask(rom_mask),
		.ram_mask(ram_mask),
		.cart_active(cart_active),
		.map_sel(map_sel),
		.info(info)
	);

	mem_request u_mem_request (
		.clk_sys(clk_sys),
		.reset(reset),
		.wr_strobe(wr_strobe),
		.wr(wr),
		.rom(rom),
		.rom_din(rom_din),
		.rom_we(rom_we),
		.aram(aram),
		.aram_we(aram_we)
	);

endmodule

// ==== tests/tb_cart_loader.sv ====
/*
 Cartridge loader testbench
 Drives cartridge and sound downloads into the loader and checks the
 ROM and audio RAM requests, the address masks and the chip code
*/
`timescale 1ns/10ps

module tb_cart_loader;

	logic clk_sys;
	logic reset;
	logic ioctl_wr;
	logic ioctl_download;
	cart_pkg::dl_addr_t ioctl_addr;
	cart_pkg::dl_word_t ioctl_dout;
	logic [7:0] ioctl_index;
	logic [23:0] ioctl_filesize;
	logic [1:0] map_sel;
	logic spc_mode;
	cart_pkg::cart_info_t info;
	cart_pkg::rom_req_t rom;
	cart_pkg::dl_word_t rom_din;
	logic rom_we;
	cart_pkg::aram_req_t aram;
	logic aram_we;

	integer seed;
	// Expected requests as {word address, data}
	logic [38:0] rom_q[$];
	logic [31:0] aram_q[$];
	int rom_pushed;
	int aram_pushed;
	int rom_toggles;
	int aram_toggles;
	logic rom_last;
	logic aram_last;

	cart_loader_top DUT (.*);

	always #20 clk_sys = ~clk_sys;

	// ============================================================
	// Reference model
	// ============================================================
	function automatic cart_pkg::cart_info_t expected_info(input cart_pkg::cart_hdr_t h,
		input logic [1:0] map);
		cart_pkg::cart_info_t e;
		logic [3:0] shift;
		logic gsu;
		e.rom_type = {6'd0, map};
		gsu = 1'b0;
		if (h.mapper == 8'h30 && h.cart_type == 8'h05 && h.company == 8'hB2)
			e.rom_type[7:4] = cart_pkg::CHIP_DSP3;
		else if (((h.mapper == 8'h20 || h.mapper == 8'h21) && h.cart_type == 8'h03) ||
			(h.mapper == 8'h30 && h.cart_type == 8'h05) ||
			(h.mapper == 8'h31 && (h.cart_type == 8'h03 || h.cart_type == 8'h05)))
			e.rom_type[7] = 1'b1;
		else if (h.mapper == 8'h20 && h.cart_type == 8'h05)
			e.rom_type[7:4] = cart_pkg::CHIP_DSP2;
		else if (h.mapper == 8'h30 && h.cart_type == 8'h03)
			e.rom_type[7:4] = cart_pkg::CHIP_DSP4;
		else if (h.mapper == 8'h30 && h.cart_type == 8'h25)
			e.rom_type[7:4] = cart_pkg::CHIP_OBC1;
		else if (h.mapper == 8'h32 && (h.cart_type == 8'h43 || h.cart_type == 8'h45))
			e.rom_type[7:4] = cart_pkg::CHIP_SDD1;
		else if (h.mapper == 8'h30 && h.cart_type == 8'hF6) begin
			e.rom_type[7:4] = cart_pkg::CHIP_ST0XX;
			e.rom_type[3] = 1'b1;
			if (h.rom_size < 4'd10)
				e.rom_type[5] = 1'b1;
		end else if (h.mapper == 8'h20 && (h.cart_type == 8'h13 || h.cart_type == 8'h14 ||
			h.cart_type == 8'h15 || h.cart_type == 8'h1A)) begin
			e.rom_type[7:4] = cart_pkg::CHIP_GSU;
			gsu = 1'b1;
		end else if (h.mapper == 8'h23 && (h.cart_type == 8'h32 || h.cart_type == 8'h34 ||
			h.cart_type == 8'h35))
			e.rom_type[7:4] = cart_pkg::CHIP_SA1;
		shift = (h.rom_size < 4'd12) ? 4'd12 : h.rom_size;
		e.rom_mask = 24'((32'd1024 << shift) - 32'd1);
		if (gsu)
			e.ram_mask = 24'h00FFFF;
		else if (h.ram_size == 4'd0)
			e.ram_mask = 24'd0;
		else
			e.ram_mask = 24'((32'd1024 << h.ram_size) - 32'd1);
		return e;
	endfunction

	// ============================================================
	// Checking helpers
	// ============================================================
	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic rand_word(output cart_pkg::dl_word_t w);
		logic [31:0] r;
		r = $random(seed);
		w = r[15:0];
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic wait_drain();
		int count;
		count = 0;
		while ((rom_toggles != rom_pushed || aram_toggles != aram_pushed) && count < 40) begin
			@(posedge clk_sys);
			count++;
		end
		assert (rom_toggles == rom_pushed && aram_toggles == aram_pushed) else begin
			$display("timeout while waiting for the expected memory requests");
			stop_on_error();
		end
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic start_download(input logic [7:0] index, input logic [23:0] size);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index <= index;
		ioctl_filesize <= size;
	endtask

	// One write pulse that also queues its expected request
	task automatic write_word(input cart_pkg::dl_addr_t addr, input cart_pkg::dl_word_t data);
		cart_pkg::dl_addr_t adj;
		cart_pkg::dl_addr_t aram_addr;
		@(posedge clk_sys);
		ioctl_wr <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		adj = addr - cart_pkg::dl_addr_t'(ioctl_filesize % 24'd1024);
		aram_addr = addr - cart_pkg::ARAM_OFFSET;
		if (ioctl_index < 8'd2) begin
			rom_q.push_back({adj[23:1], data});
			rom_pushed++;
		end else if (ioctl_index == 8'd2 && addr < cart_pkg::ARAM_LIMIT) begin
			aram_q.push_back({aram_addr[15:0], data});
			aram_pushed++;
		end
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		ioctl_download <= 1'b0;
	endtask

	task automatic load_cart(input logic [1:0] map, input logic copier,
		input logic [7:0] mapper, input logic [7:0] ctype, input logic [7:0] company,
		input logic [3:0] rom_size, input logic [3:0] ram_size);
		cart_pkg::cart_hdr_t h;
		cart_pkg::cart_info_t e;
		cart_pkg::dl_addr_t base;
		cart_pkg::dl_word_t w;
		h.mapper = mapper;
		h.cart_type = ctype;
		h.company = company;
		h.rom_size = rom_size;
		h.ram_size = ram_size;
		case (map)
			2'd1: base = 25'h0008000;
			2'd2: base = 25'h0408000;
			default: base = 25'h0000000;
		endcase
		if (copier)
			base = base + 25'd512;
		@(posedge clk_sys);
		map_sel <= map;
		start_download({7'd0, map[1]}, copier ? 24'h080200 : 24'h080000);
		// Copier header area and image start written back to back
		for (int i = 0; i < 8; i++) begin
			rand_word(w);
			write_word(25'(i * 130), w);
		end
		rand_word(w);
		write_word(base + 25'h7FD4, {h.mapper, w[7:0]});
		rand_word(w);
		write_word(base + 25'h7FD6, {w[15:12], h.rom_size, h.cart_type});
		rand_word(w);
		write_word(base + 25'h7FD8, {w[15:4], h.ram_size});
		rand_word(w);
		write_word(base + 25'h7FDA, {w[15:8], h.company});
		end_download();
		wait_cycles(2);
		wait_drain();
		@(negedge clk_sys);
		e = expected_info(h, map);
		check_value("info.rom_type", 32'(info.rom_type), 32'(e.rom_type));
		check_value("info.rom_mask", 32'(info.rom_mask), 32'(e.rom_mask));
		check_value("info.ram_mask", 32'(info.ram_mask), 32'(e.ram_mask));
		check_value("spc_mode", 32'(spc_mode), 32'd0);
	endtask

	task automatic load_spc();
		cart_pkg::dl_word_t w;
		start_download(8'd2, 24'h010200);
		for (int i = 0; i < 6; i++) begin
			rand_word(w);
			write_word(25'(i * 64), w);
		end
		// Last two sit past the audio RAM window
		for (int i = 0; i < 4; i++) begin
			rand_word(w);
			write_word(25'h00100FC + 25'(i * 2), w);
		end
		end_download();
		wait_drain();
		@(negedge clk_sys);
		check_value("spc_mode", 32'(spc_mode), 32'd1);
	endtask

	// ============================================================
	// Request monitor
	// ============================================================
	always @(negedge clk_sys) begin
		logic [38:0] rom_exp;
		logic [31:0] aram_exp;
		if (reset) begin
			rom_last = 1'b0;
			aram_last = 1'b0;
		end else begin
			if (rom.req !== rom_last) begin
				rom_last = rom.req;
				rom_toggles++;
				assert (rom_q.size() > 0) else begin
					$display("ROM request toggled at %0t ns with no write pending", $time);
					stop_on_error();
				end
				rom_exp = rom_q.pop_front();
				check_value("rom.addr", 32'(rom.addr), 32'(rom_exp[38:16]));
				check_value("rom_din", 32'(rom_din), 32'(rom_exp[15:0]));
				check_value("rom_we", 32'(rom_we), 32'd1);
			end
			if (aram.req !== aram_last) begin
				aram_last = aram.req;
				aram_toggles++;
				assert (aram_q.size() > 0) else begin
					$display("audio RAM request toggled at %0t ns with no write pending", $time);
					stop_on_error();
				end
				aram_exp = aram_q.pop_front();
				check_value("aram.addr", 32'(aram.addr), 32'(aram_exp[31:16]));
				check_value("aram.data", 32'(aram.data), 32'(aram_exp[15:0]));
				check_value("aram_we", 32'(aram_we), 32'd1);
			end
		end
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		seed = 32'hda51;
		clk_sys = 1'b0;
		reset = 1'b1;
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_index = 8'd0;
		ioctl_filesize = 24'd0;
		map_sel = 2'd0;
		rom_pushed = 0;
		aram_pushed = 0;
		rom_toggles = 0;
		aram_toggles = 0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_value("spc_mode", 32'(spc_mode), 32'd0);
		check_value("rom.req", 32'(rom.req), 32'd0);
		check_value("aram.req", 32'(aram.req), 32'd0);
		check_value("info.rom_type", 32'(info.rom_type), 32'd0);
		check_value("info.rom_mask", 32'(info.rom_mask), 32'd0);
		check_value("info.ram_mask", 32'(info.ram_mask), 32'd0);
		check_value("aram_we", 32'(aram_we), 32'd1);

		// Plain LoROM, HiROM DSP1, headerless ExHiROM
		load_cart(2'd0, 1'b1, 8'h20, 8'h00, 8'h01, 4'd5, 4'd3);
		load_cart(2'd1, 1'b1, 8'h21, 8'h03, 8'h01, 4'd11, 4'd0);
		load_cart(2'd2, 1'b0, 8'h25, 8'h02, 8'h01, 4'd13, 4'd3);
		// Coprocessor boards
		load_cart(2'd0, 1'b1, 8'h30, 8'h25, 8'h01, 4'd9, 4'd1);
		load_cart(2'd0, 1'b1, 8'h20, 8'h15, 8'h01, 4'd10, 4'd5);
		load_cart(2'd0, 1'b1, 8'h23, 8'h35, 8'h01, 4'd12, 4'd2);
		load_cart(2'd0, 1'b1, 8'h30, 8'hF6, 8'h01, 4'd9, 4'd0);
		load_cart(2'd0, 1'b1, 8'h30, 8'h05, 8'hB2, 4'd10, 4'd0);

		// Sound program followed by a cartridge that clears the sound mode
		load_spc();
		load_cart(2'd1, 1'b1, 8'h31, 8'h05, 8'h01, 4'd12, 4'd4);

		// Any late request toggle still reaches the monitor
		wait_cycles(4);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
common/cart_pkg.sv
source/download_decode.sv
header/header_capture.sv
header/chip_detect.sv
source/mem_request.sv
source/cart_loader_top.sv
tests/tb_cart_loader.sv

// ==== run.sh ====
#!/bin/sh
# Build the cartridge loader testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_cart_loader \
	-Mdir obj_dir -o sim_cart_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_cart_loader > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

grep -q "^Test passed$" sim.log
if [ $? -ne 0 ]; then
	echo "pass message not found in sim.log"
	exit 1
fi

exit 0
